// ==== hdl/lsu_conf_pkg.sv ====
package lsu_conf_pkg;

// ------------------------------
// Datapath
// ------------------------------
localparam int XLEN_W       = 32;
localparam int LSU_INST_NUM = 2;
localparam int RD_TAG_W     = 5;

// ------------------------------
// Cache geometry
// ------------------------------
// One word per line, direct mapped
localparam int DCACHE_LINES  = 16;
localparam int DCACHE_IDX_W  = 4;
localparam int DCACHE_BANKS  = 2;
localparam int DCACHE_BANK_W = $clog2(DCACHE_BANKS);

// Byte address, word offset is dropped
localparam int PADDR_W      = 16;
localparam int DCACHE_OFS_W = 2;
localparam int TAG_W        = PADDR_W - DCACHE_IDX_W - DCACHE_OFS_W;

// ------------------------------
// Read port map
// ------------------------------
// Pipelines first, snoop read last
localparam int RD_PORT_NUM    = LSU_INST_NUM + 1;
localparam int L1D_SNOOP_PORT = RD_PORT_NUM - 1;

endpackage

// ==== hdl/lsu_types_pkg.sv ====
package lsu_types_pkg;

import lsu_conf_pkg::*;

// ------------------------------
// Operation category
// ------------------------------
typedef enum logic {
  INST_CAT_LD = 1'b0,
  INST_CAT_ST = 1'b1
} inst_cat_t;

// ------------------------------
// Cache access result
// ------------------------------
typedef enum logic [1:0] {
  STATUS_NONE         = 2'b00,
  STATUS_HIT          = 2'b01,
  STATUS_MISS         = 2'b10,
  STATUS_L1D_CONFLICT = 2'b11
} access_status_t;

// External snoop request
typedef enum logic {
  SNOOP_READ    = 1'b0,
  SNOOP_INVALID = 1'b1
} snoop_cmd_t;

// ------------------------------
// Dispatch payload word
// ------------------------------
// Loads carry the destination tag in the low bits,
// stores carry the full word to be written
typedef union packed {
  struct packed {
    logic [XLEN_W-RD_TAG_W-1:0] pad;
    logic [RD_TAG_W-1:0]        rd_tag;
  } ld;
  logic [XLEN_W-1:0] st_data;
} mem_payload_t;

endpackage

// ==== hdl/lsu_dispatch.sv ====
`timescale 1ns/10ps

module lsu_dispatch
  import lsu_conf_pkg::*, lsu_types_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  input  logic [LSU_INST_NUM-1:0] i_disp_valid,
  input  inst_cat_t               i_disp_cat     [LSU_INST_NUM],
  input  logic [PADDR_W-1:0]      i_disp_paddr   [LSU_INST_NUM],
  input  mem_payload_t            i_disp_payload [LSU_INST_NUM],

  output logic [LSU_INST_NUM-1:0] o_req_valid,
  output logic [LSU_INST_NUM-1:0] o_req_is_store,
  output logic [DCACHE_IDX_W-1:0] o_req_idx     [LSU_INST_NUM],
  output logic [TAG_W-1:0]        o_req_tag     [LSU_INST_NUM],
  output logic [XLEN_W-1:0]       o_req_payload [LSU_INST_NUM]
);

logic [XLEN_W-1:0] w_payload [LSU_INST_NUM];

// Unpack the payload union by category
// Loads keep only the destination tag, stores keep the word
always_comb begin
  for (int s = 0; s < LSU_INST_NUM; s++) begin
    if (i_disp_cat[s] == INST_CAT_ST) begin
      w_payload[s] = i_disp_payload[s].st_data;
    end else begin
      w_payload[s] = {{(XLEN_W-RD_TAG_W){1'b0}}, i_disp_payload[s].ld.rd_tag};
    end
  end
end

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    o_req_valid <= '0;
  end else begin
    o_req_valid <= i_disp_valid;
  end
end

// Request fields, only captured with a valid slot
always_ff @(posedge i_clk) begin
  for (int s = 0; s < LSU_INST_NUM; s++) begin
    if (i_disp_valid[s]) begin
      o_req_is_store[s] <= (i_disp_cat[s] == INST_CAT_ST);
      o_req_idx[s]      <= i_disp_paddr[s][DCACHE_OFS_W +: DCACHE_IDX_W];
      o_req_tag[s]      <= i_disp_paddr[s][PADDR_W-1 -: TAG_W];
      o_req_payload[s]  <= w_payload[s];
    end
  end
end

endmodule

// ==== hdl/lsu_pipe.sv ====
`timescale 1ns/10ps

module lsu_pipe
  import lsu_conf_pkg::*, lsu_types_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Request from dispatch
  input  logic                    i_req_valid,
  input  logic                    i_req_is_store,
  input  logic [DCACHE_IDX_W-1:0] i_req_idx,
  input  logic [TAG_W-1:0]        i_req_tag,
  input  logic [XLEN_W-1:0]       i_req_payload,

  // Cache read port
  output logic                    o_rd_valid,
  output logic [DCACHE_IDX_W-1:0] o_rd_idx,
  output logic [TAG_W-1:0]        o_rd_tag,
  input  logic                    i_rd_hit,
  input  logic                    i_rd_miss,
  input  logic                    i_rd_conflict,
  input  logic [XLEN_W-1:0]       i_rd_data,

  // Cache store write port
  output logic                    o_st_valid,
  output logic [DCACHE_IDX_W-1:0] o_st_idx,
  output logic [XLEN_W-1:0]       o_st_data,

  // Done report
  output logic                    o_done_valid,
  output access_status_t          o_done_status,
  output logic [XLEN_W-1:0]       o_done_data,
  output logic [RD_TAG_W-1:0]     o_done_rd_tag
);

logic                    r_s1_valid;
logic                    r_s1_is_store;
logic [DCACHE_IDX_W-1:0] r_s1_idx;
logic [RD_TAG_W-1:0]     r_s1_rd_tag;
logic [XLEN_W-1:0]       r_s1_st_data;
access_status_t          w_s1_status;

// ------------------------------
// s0 : cache read
// ------------------------------
assign o_rd_valid = i_req_valid;
assign o_rd_idx   = i_req_idx;
assign o_rd_tag   = i_req_tag;

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_s1_valid <= 1'b0;
  end else begin
    r_s1_valid <= i_req_valid;
  end
end

// Operation context follows the read into s1
always_ff @(posedge i_clk) begin
  if (i_req_valid) begin
    r_s1_is_store <= i_req_is_store;
    r_s1_idx      <= i_req_idx;
    r_s1_rd_tag   <= i_req_payload[RD_TAG_W-1:0];
    r_s1_st_data  <= i_req_payload;
  end
end

// ------------------------------
// s1 : result and store write
// ------------------------------
always_comb begin
  w_s1_status = STATUS_NONE;
  if (r_s1_valid) begin
    if (i_rd_conflict) begin
      w_s1_status = STATUS_L1D_CONFLICT;
    end else if (i_rd_hit) begin
      w_s1_status = STATUS_HIT;
    end else if (i_rd_miss) begin
      w_s1_status = STATUS_MISS;
    end
  end
end

// Stores write only on a hit, nothing to refill
assign o_st_valid = r_s1_valid & r_s1_is_store & (w_s1_status == STATUS_HIT);
assign o_st_idx   = r_s1_idx;
assign o_st_data  = r_s1_st_data;

// ------------------------------
// ex2 : done report
// ------------------------------
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    o_done_valid  <= 1'b0;
    o_done_status <= STATUS_NONE;
  end else begin
    o_done_valid  <= r_s1_valid;
    o_done_status <= w_s1_status;
  end
end

always_ff @(posedge i_clk) begin
  if (!r_s1_is_store && w_s1_status == STATUS_HIT) begin
    o_done_data <= i_rd_data;
  end else begin
    o_done_data <= '0;
  end
  o_done_rd_tag <= r_s1_is_store ? '0 : r_s1_rd_tag;
end

endmodule

// ==== hdl/lsu_dcache.sv ====
`timescale 1ns/10ps

module lsu_dcache
  import lsu_conf_pkg::*, lsu_types_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Pipeline read ports
  input  logic [LSU_INST_NUM-1:0] i_rd_valid,
  input  logic [DCACHE_IDX_W-1:0] i_rd_idx  [LSU_INST_NUM],
  input  logic [TAG_W-1:0]        i_rd_tag  [LSU_INST_NUM],
  output logic [LSU_INST_NUM-1:0] o_rd_hit,
  output logic [LSU_INST_NUM-1:0] o_rd_miss,
  output logic [LSU_INST_NUM-1:0] o_rd_conflict,
  output logic [XLEN_W-1:0]       o_rd_data [LSU_INST_NUM],

  // Store hit writes
  input  logic [LSU_INST_NUM-1:0] i_st_valid,
  input  logic [DCACHE_IDX_W-1:0] i_st_idx  [LSU_INST_NUM],
  input  logic [XLEN_W-1:0]       i_st_data [LSU_INST_NUM],

  // Line fill
  input  logic                    i_fill_valid,
  input  logic [PADDR_W-1:0]      i_fill_paddr,
  input  logic [XLEN_W-1:0]       i_fill_data,

  // External snoop
  input  logic                    i_snoop_valid,
  input  snoop_cmd_t              i_snoop_cmd,
  input  logic [PADDR_W-1:0]      i_snoop_paddr,
  output logic                    o_snoop_resp_valid,
  output access_status_t          o_snoop_resp_status,
  output logic [XLEN_W-1:0]       o_snoop_resp_data
);

// Line state
logic [DCACHE_LINES-1:0] r_valid;
logic [TAG_W-1:0]        r_tag  [DCACHE_LINES];
logic [XLEN_W-1:0]       r_data [DCACHE_LINES];

// Merged read ports, snoop read on the last one
logic [RD_PORT_NUM-1:0]  w_rd_valid;
logic [DCACHE_IDX_W-1:0] w_rd_idx  [RD_PORT_NUM];
logic [TAG_W-1:0]        w_rd_tag  [RD_PORT_NUM];
logic [RD_PORT_NUM-1:0]  w_rd_grant;
logic [RD_PORT_NUM-1:0]  w_rd_match;

logic [RD_PORT_NUM-1:0]  r_rd_hit;
logic [RD_PORT_NUM-1:0]  r_rd_miss;
logic [RD_PORT_NUM-1:0]  r_rd_conflict;
logic [XLEN_W-1:0]       r_rd_data [RD_PORT_NUM];

logic [DCACHE_IDX_W-1:0] w_fill_idx;
logic [DCACHE_IDX_W-1:0] w_snoop_idx;
logic                    w_snoop_inv;

assign w_fill_idx  = i_fill_paddr[DCACHE_OFS_W +: DCACHE_IDX_W];
assign w_snoop_idx = i_snoop_paddr[DCACHE_OFS_W +: DCACHE_IDX_W];
assign w_snoop_inv = i_snoop_valid & (i_snoop_cmd == SNOOP_INVALID);

// ------------------------------
// Read port arbitration
// ------------------------------
always_comb begin
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    w_rd_valid[p] = i_rd_valid[p];
    w_rd_idx[p]   = i_rd_idx[p];
    w_rd_tag[p]   = i_rd_tag[p];
  end
  w_rd_valid[L1D_SNOOP_PORT] = i_snoop_valid & (i_snoop_cmd == SNOOP_READ);
  w_rd_idx[L1D_SNOOP_PORT]   = w_snoop_idx;
  w_rd_tag[L1D_SNOOP_PORT]   = i_snoop_paddr[PADDR_W-1 -: TAG_W];
end

// Fixed priority inside a bank, lowest port wins
always_comb begin
  for (int p = 0; p < RD_PORT_NUM; p++) begin
    w_rd_grant[p] = w_rd_valid[p];
    for (int q = 0; q < p; q++) begin
      if (w_rd_valid[q] &&
          w_rd_idx[q][DCACHE_BANK_W-1:0] == w_rd_idx[p][DCACHE_BANK_W-1:0]) begin
        w_rd_grant[p] = 1'b0;
      end
    end
    w_rd_match[p] = r_valid[w_rd_idx[p]] && (r_tag[w_rd_idx[p]] == w_rd_tag[p]);
  end
end

always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_rd_hit      <= '0;
    r_rd_miss     <= '0;
    r_rd_conflict <= '0;
  end else begin
    r_rd_hit      <= w_rd_grant & w_rd_match;
    r_rd_miss     <= w_rd_grant & ~w_rd_match;
    r_rd_conflict <= w_rd_valid & ~w_rd_grant;
  end
end

// Data is zero unless the granted read hits
always_ff @(posedge i_clk) begin
  for (int p = 0; p < RD_PORT_NUM; p++) begin
    r_rd_data[p] <= (w_rd_grant[p] && w_rd_match[p]) ? r_data[w_rd_idx[p]] : '0;
  end
end

assign o_rd_hit      = r_rd_hit[LSU_INST_NUM-1:0];
assign o_rd_miss     = r_rd_miss[LSU_INST_NUM-1:0];
assign o_rd_conflict = r_rd_conflict[LSU_INST_NUM-1:0];

always_comb begin
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    o_rd_data[p] = r_rd_data[p];
  end
end

// ------------------------------
// Array updates
// ------------------------------
// Later assignments win: invalidate over fill over store
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    r_valid <= '0;
  end else begin
    if (i_fill_valid) begin
      r_valid[w_fill_idx] <= 1'b1;
    end
    if (w_snoop_inv) begin
      r_valid[w_snoop_idx] <= 1'b0;
    end
  end
end

always_ff @(posedge i_clk) begin
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    if (i_st_valid[p]) begin
      r_data[i_st_idx[p]] <= i_st_data[p];
    end
  end
  if (i_fill_valid) begin
    r_tag[w_fill_idx]  <= i_fill_paddr[PADDR_W-1 -: TAG_W];
    r_data[w_fill_idx] <= i_fill_data;
  end
end

// ------------------------------
// Snoop response
// ------------------------------
always_ff @(posedge i_clk, negedge i_reset_n) begin
  if (!i_reset_n) begin
    o_snoop_resp_valid <= 1'b0;
  end else begin
    o_snoop_resp_valid <= i_snoop_valid;
  end
end

// An invalidate has no read flags and reports NONE
always_comb begin
  o_snoop_resp_status = STATUS_NONE;
  if (o_snoop_resp_valid) begin
    if (r_rd_conflict[L1D_SNOOP_PORT]) begin
      o_snoop_resp_status = STATUS_L1D_CONFLICT;
    end else if (r_rd_hit[L1D_SNOOP_PORT]) begin
      o_snoop_resp_status = STATUS_HIT;
    end else if (r_rd_miss[L1D_SNOOP_PORT]) begin
      o_snoop_resp_status = STATUS_MISS;
    end
  end
end

assign o_snoop_resp_data = r_rd_data[L1D_SNOOP_PORT];

endmodule

// ==== hdl/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top
  import lsu_conf_pkg::*, lsu_types_pkg::*;
(
  input  logic                    i_clk,
  input  logic                    i_reset_n,

  // Dispatch slots
  input  logic [LSU_INST_NUM-1:0] i_disp_valid,
  input  inst_cat_t               i_disp_cat     [LSU_INST_NUM],
  input  logic [PADDR_W-1:0]      i_disp_paddr   [LSU_INST_NUM],
  input  mem_payload_t            i_disp_payload [LSU_INST_NUM],

  // Line fill
  input  logic                    i_fill_valid,
  input  logic [PADDR_W-1:0]      i_fill_paddr,
  input  logic [XLEN_W-1:0]       i_fill_data,

  // External snoop
  input  logic                    i_snoop_valid,
  input  snoop_cmd_t              i_snoop_cmd,
  input  logic [PADDR_W-1:0]      i_snoop_paddr,

  // Done reports
  output logic [LSU_INST_NUM-1:0] o_done_valid,
  output access_status_t          o_done_status [LSU_INST_NUM],
  output logic [XLEN_W-1:0]       o_done_data   [LSU_INST_NUM],
  output logic [RD_TAG_W-1:0]     o_done_rd_tag [LSU_INST_NUM],

  output logic                    o_snoop_resp_valid,
  output access_status_t          o_snoop_resp_status,
  output logic [XLEN_W-1:0]       o_snoop_resp_data
);

// Dispatch to pipelines
logic [LSU_INST_NUM-1:0] w_req_valid;
logic [LSU_INST_NUM-1:0] w_req_is_store;
logic [DCACHE_IDX_W-1:0] w_req_idx     [LSU_INST_NUM];
logic [TAG_W-1:0]        w_req_tag     [LSU_INST_NUM];
logic [XLEN_W-1:0]       w_req_payload [LSU_INST_NUM];

// Pipelines to cache
logic [LSU_INST_NUM-1:0] w_rd_valid;
logic [DCACHE_IDX_W-1:0] w_rd_idx [LSU_INST_NUM];
logic [TAG_W-1:0]        w_rd_tag [LSU_INST_NUM];
logic [LSU_INST_NUM-1:0] w_rd_hit;
logic [LSU_INST_NUM-1:0] w_rd_miss;
logic [LSU_INST_NUM-1:0] w_rd_conflict;
logic [XLEN_W-1:0]       w_rd_data [LSU_INST_NUM];
logic [LSU_INST_NUM-1:0] w_st_valid;
logic [DCACHE_IDX_W-1:0] w_st_idx  [LSU_INST_NUM];
logic [XLEN_W-1:0]       w_st_data [LSU_INST_NUM];

lsu_dispatch u_dispatch (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_disp_valid   (i_disp_valid),
  .i_disp_cat     (i_disp_cat),
  .i_disp_paddr   (i_disp_paddr),
  .i_disp_payload (i_disp_payload),
  .o_req_valid    (w_req_valid),
  .o_req_is_store (w_req_is_store),
  .o_req_idx      (w_req_idx),
  .o_req_tag      (w_req_tag),
  .o_req_payload  (w_req_payload)
);

generate for (genvar lsu_idx = 0; lsu_idx < LSU_INST_NUM; lsu_idx++) begin : lsu_loop
  lsu_pipe u_pipe (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_req_valid    (w_req_valid   [lsu_idx]),
    .i_req_is_store (w_req_is_store[lsu_idx]),
    .i_req_idx      (w_req_idx     [lsu_idx]),
    .i_req_tag      (w_req_tag     [lsu_idx]),
    .i_req_payload  (w_req_payload [lsu_idx]),
    .o_rd_valid     (w_rd_valid    [lsu_idx]),
    .o_rd_idx       (w_rd_idx      [lsu_idx]),
    .o_rd_tag       (w_rd_tag      [lsu_idx]),
    .i_rd_hit       (w_rd_hit      [lsu_idx]),
    .i_rd_miss      (w_rd_miss     [lsu_idx]),
    .i_rd_conflict  (w_rd_conflict [lsu_idx]),
    .i_rd_data      (w_rd_data     [lsu_idx]),
    .o_st_valid     (w_st_valid    [lsu_idx]),
    .o_st_idx       (w_st_idx      [lsu_idx]),
    .o_st_data      (w_st_data     [lsu_idx]),
    .o_done_valid   (o_done_valid  [lsu_idx]),
    .o_done_status  (o_done_status [lsu_idx]),
    .o_done_data    (o_done_data   [lsu_idx]),
    .o_done_rd_tag  (o_done_rd_tag [lsu_idx])
  );
end
endgenerate

lsu_dcache u_dcache (
  .i_clk               (i_clk),
  .i_reset_n           (i_reset_n),
  .i_rd_valid          (w_rd_valid),
  .i_rd_idx            (w_rd_idx),
  .i_rd_tag            (w_rd_tag),
  .o_rd_hit            (w_rd_hit),
  .o_rd_miss           (w_rd_miss),
  .o_rd_conflict       (w_rd_conflict),
  .o_rd_data           (w_rd_data),
  .i_st_valid          (w_st_valid),
  .i_st_idx            (w_st_idx),
  .i_st_data           (w_st_data),
  .i_fill_valid        (i_fill_valid),
  .i_fill_paddr        (i_fill_paddr),
  .i_fill_data         (i_fill_data),
  .i_snoop_valid       (i_snoop_valid),
  .i_snoop_cmd         (i_snoop_cmd),
  .i_snoop_paddr       (i_snoop_paddr),
  .o_snoop_resp_valid  (o_snoop_resp_valid),
  .o_snoop_resp_status (o_snoop_resp_status),
  .o_snoop_resp_data   (o_snoop_resp_data)
);

endmodule

// ==== verif/tb_lsu_top_sva.sv ====
`timescale 1ns/10ps

module lsu_top_sva
  import lsu_conf_pkg::*, lsu_types_pkg::*;
(
  input logic                    i_clk,
  input logic                    i_reset_n,
  input logic [LSU_INST_NUM-1:0] i_disp_valid,
  input logic                    i_snoop_valid,
  input logic [LSU_INST_NUM-1:0] i_done_valid,
  input access_status_t          i_done_status [LSU_INST_NUM],
  input logic                    i_snoop_resp_valid
);

// Number of failed assertions
int fail_cnt = 0;

for (genvar p = 0; p < LSU_INST_NUM; p++) begin : pipe_chk
  // No status without a done report
  a_idle_status: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_done_valid[p] |-> i_done_status[p] == STATUS_NONE)
    else begin
      $error("pipe %0d shows a status while done valid is low", p);
      fail_cnt++;
    end

  // Dispatch register, s0 read, ex2 report
  a_done_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_done_valid[p] == $past(i_disp_valid[p], 3))
    else begin
      $error("pipe %0d done valid is not 3 cycles after its slot valid", p);
      fail_cnt++;
    end
end

a_snoop_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n)
  i_snoop_resp_valid == $past(i_snoop_valid))
  else begin
    $error("snoop response valid is not 1 cycle after the snoop request");
    fail_cnt++;
  end

endmodule

bind lsu_top lsu_top_sva u_lsu_top_sva (
  .i_clk              (i_clk),
  .i_reset_n          (i_reset_n),
  .i_disp_valid       (i_disp_valid),
  .i_snoop_valid      (i_snoop_valid),
  .i_done_valid       (o_done_valid),
  .i_done_status      (o_done_status),
  .i_snoop_resp_valid (o_snoop_resp_valid)
);

// ==== verif/tb_lsu_top.sv ====
`timescale 1ns/10ps

module tb_lsu_top
  import lsu_conf_pkg::*, lsu_types_pkg::*;
();

localparam int WAIT_LIMIT = 8;
localparam int FILLER_NUM = 8;

// One table row with stimulus for both slots, fill, snoop and the expected results
typedef struct {
  string                                   name;
  logic         [LSU_INST_NUM-1:0]         disp_valid;
  inst_cat_t    [LSU_INST_NUM-1:0]         cat;
  logic         [LSU_INST_NUM-1:0][PADDR_W-1:0] paddr;
  mem_payload_t [LSU_INST_NUM-1:0]         payload;
  logic                                    fill_valid;
  logic         [PADDR_W-1:0]              fill_paddr;
  logic         [XLEN_W-1:0]               fill_data;
  logic                                    snoop_valid;
  snoop_cmd_t                              snoop_cmd;
  logic         [PADDR_W-1:0]              snoop_paddr;
  access_status_t [LSU_INST_NUM-1:0]       exp_status;
  logic         [LSU_INST_NUM-1:0][XLEN_W-1:0]   exp_data;
  logic         [LSU_INST_NUM-1:0][RD_TAG_W-1:0] exp_rd_tag;
  access_status_t                          exp_snoop_status;
  logic         [XLEN_W-1:0]               exp_snoop_data;
} step_t;

logic                    i_clk;
logic                    i_reset_n;
logic [LSU_INST_NUM-1:0] i_disp_valid;
inst_cat_t               i_disp_cat     [LSU_INST_NUM];
logic [PADDR_W-1:0]      i_disp_paddr   [LSU_INST_NUM];
mem_payload_t            i_disp_payload [LSU_INST_NUM];
logic                    i_fill_valid;
logic [PADDR_W-1:0]      i_fill_paddr;
logic [XLEN_W-1:0]       i_fill_data;
logic                    i_snoop_valid;
snoop_cmd_t              i_snoop_cmd;
logic [PADDR_W-1:0]      i_snoop_paddr;
logic [LSU_INST_NUM-1:0] o_done_valid;
access_status_t          o_done_status [LSU_INST_NUM];
logic [XLEN_W-1:0]       o_done_data   [LSU_INST_NUM];
logic [RD_TAG_W-1:0]     o_done_rd_tag [LSU_INST_NUM];
logic                    o_snoop_resp_valid;
access_status_t          o_snoop_resp_status;
logic [XLEN_W-1:0]       o_snoop_resp_data;

// Reference model of the cache lines
logic              m_valid [DCACHE_LINES];
logic [TAG_W-1:0]  m_tag   [DCACHE_LINES];
logic [XLEN_W-1:0] m_data  [DCACHE_LINES];

step_t  steps[$];
step_t  st;
integer seed;
int     cycle_cnt = 0;
int     err_cnt   = 0;
int     check_cnt = 0;
int     test_cnt  = 0;

lsu_top dut (.*);

always #4 i_clk = ~i_clk;

always @(posedge i_clk) begin
  cycle_cnt <= cycle_cnt + 1;
end

// ------------------------------
// Checks
// ------------------------------
task automatic report_failure(input string msg);
  err_cnt++;
  $display("Error: %s", msg);
endtask

task automatic check_status(input string name, input access_status_t exp,
                            input access_status_t act);
  check_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Mismatch %s: expected %s, actual %s", name, exp.name(), act.name());
  end
endtask

task automatic check_data(input string name, input logic [XLEN_W-1:0] exp,
                          input logic [XLEN_W-1:0] act);
  check_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Mismatch %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_rd_tag(input string name, input logic [RD_TAG_W-1:0] exp,
                            input logic [RD_TAG_W-1:0] act);
  check_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

// ------------------------------
// Table building
// ------------------------------
function automatic logic [PADDR_W-1:0] make_addr(input int tag, input int idx);
  return {tag[TAG_W-1:0], idx[DCACHE_IDX_W-1:0], {DCACHE_OFS_W{1'b0}}};
endfunction

function automatic int idx_of(input logic [PADDR_W-1:0] addr);
  return int'(addr[DCACHE_OFS_W +: DCACHE_IDX_W]);
endfunction

function automatic logic model_hit(input logic [PADDR_W-1:0] addr);
  return m_valid[idx_of(addr)] && (m_tag[idx_of(addr)] == addr[PADDR_W-1 -: TAG_W]);
endfunction

task automatic new_step(input string name);
  st.name        = name;
  st.disp_valid  = '0;
  st.fill_valid  = 1'b0;
  st.fill_paddr  = '0;
  st.fill_data   = '0;
  st.snoop_valid = 1'b0;
  st.snoop_cmd   = SNOOP_READ;
  st.snoop_paddr = '0;
  st.exp_snoop_status = STATUS_NONE;
  st.exp_snoop_data   = '0;
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    st.cat[p]        = INST_CAT_LD;
    st.paddr[p]      = '0;
    st.payload[p]    = '0;
    st.exp_status[p] = STATUS_NONE;
    st.exp_data[p]   = '0;
    st.exp_rd_tag[p] = '0;
  end
endtask

// Load words carry the destination tag in the low bits
task automatic set_slot(input int s, input inst_cat_t cat, input logic [PADDR_W-1:0] addr,
                        input logic [XLEN_W-1:0] word, input access_status_t status,
                        input logic [XLEN_W-1:0] data);
  st.disp_valid[s]         = 1'b1;
  st.cat[s]                = cat;
  st.paddr[s]              = addr;
  st.payload[s].st_data    = word;
  st.exp_status[s]         = status;
  st.exp_data[s]           = data;
  st.exp_rd_tag[s]         = (cat == INST_CAT_ST) ? '0 : word[RD_TAG_W-1:0];
endtask

// Fill lands before the pipes read and updates the model at once
task automatic set_fill(input logic [PADDR_W-1:0] addr, input logic [XLEN_W-1:0] data);
  st.fill_valid = 1'b1;
  st.fill_paddr = addr;
  st.fill_data  = data;
  m_valid[idx_of(addr)] = 1'b1;
  m_tag[idx_of(addr)]   = addr[PADDR_W-1 -: TAG_W];
  m_data[idx_of(addr)]  = data;
endtask

task automatic set_snoop(input snoop_cmd_t cmd, input logic [PADDR_W-1:0] addr,
                         input access_status_t status, input logic [XLEN_W-1:0] data);
  st.snoop_valid      = 1'b1;
  st.snoop_cmd        = cmd;
  st.snoop_paddr      = addr;
  st.exp_snoop_status = status;
  st.exp_snoop_data   = data;
endtask

task automatic push_step();
  if (st.snoop_valid && st.snoop_cmd == SNOOP_INVALID) begin
    m_valid[idx_of(st.snoop_paddr)] = 1'b0;
  end
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    if (st.disp_valid[p] && st.cat[p] == INST_CAT_ST && st.exp_status[p] == STATUS_HIT) begin
      m_data[idx_of(st.paddr[p])] = st.payload[p].st_data;
    end
  end
  steps.push_back(st);
endtask

// Random fill plus two loads checked against the model
task automatic add_filler(input int n);
  logic [PADDR_W-1:0] a;
  logic [PADDR_W-1:0] b;
  logic [XLEN_W-1:0]  d;
  a = $random(seed);
  b = $random(seed);
  d = $random(seed);
  new_step($sformatf("random_%0d", n));
  set_fill(a, d);
  set_slot(0, INST_CAT_LD, a, n % 32, STATUS_HIT, d);
  if (a[DCACHE_OFS_W] == b[DCACHE_OFS_W]) begin
    set_slot(1, INST_CAT_LD, b, (n + 7) % 32, STATUS_L1D_CONFLICT, '0);
  end else if (model_hit(b)) begin
    set_slot(1, INST_CAT_LD, b, (n + 7) % 32, STATUS_HIT, m_data[idx_of(b)]);
  end else begin
    set_slot(1, INST_CAT_LD, b, (n + 7) % 32, STATUS_MISS, '0);
  end
  push_step();
endtask

task automatic build_table();
  logic [PADDR_W-1:0] a;
  logic [PADDR_W-1:0] c;
  a = make_addr(3, 4);
  c = make_addr(2, 7);
  new_step("reset_load_miss");
  set_slot(0, INST_CAT_LD, a, 5, STATUS_MISS, '0);
  push_step();
  new_step("fill_load_hit");
  set_fill(a, 32'h1234_5678);
  set_slot(0, INST_CAT_LD, a, 7, STATUS_HIT, 32'h1234_5678);
  push_step();
  new_step("tag_mismatch_miss");
  set_slot(0, INST_CAT_LD, make_addr(9, 4), 2, STATUS_MISS, '0);
  push_step();
  new_step("store_hit");
  set_slot(0, INST_CAT_ST, a, 32'hcafe_f00d, STATUS_HIT, '0);
  push_step();
  new_step("load_after_store");
  set_slot(0, INST_CAT_LD, a, 1, STATUS_HIT, 32'hcafe_f00d);
  push_step();
  new_step("fill_other_line");
  set_fill(c, 32'h0bad_cafe);
  push_step();
  new_step("store_miss");
  set_slot(1, INST_CAT_ST, make_addr(6, 7), 32'hdead_beef, STATUS_MISS, '0);
  push_step();
  new_step("load_after_store_miss");
  set_slot(1, INST_CAT_LD, c, 9, STATUS_HIT, 32'h0bad_cafe);
  push_step();
  new_step("same_bank_conflict");
  set_slot(0, INST_CAT_LD, a, 3, STATUS_HIT, 32'hcafe_f00d);
  set_slot(1, INST_CAT_LD, make_addr(2, 6), 4, STATUS_L1D_CONFLICT, '0);
  push_step();
  new_step("diff_bank_both");
  set_slot(0, INST_CAT_LD, a, 11, STATUS_HIT, 32'hcafe_f00d);
  set_slot(1, INST_CAT_LD, c, 12, STATUS_HIT, 32'h0bad_cafe);
  push_step();
  new_step("snoop_read_hit");
  set_snoop(SNOOP_READ, a, STATUS_HIT, 32'hcafe_f00d);
  push_step();
  new_step("snoop_invalidate");
  set_snoop(SNOOP_INVALID, a, STATUS_NONE, '0);
  push_step();
  new_step("load_after_invalidate");
  set_slot(0, INST_CAT_LD, a, 13, STATUS_MISS, '0);
  push_step();
  // Snoop goes out in the cycle of the pipe's cache read
  new_step("snoop_conflict");
  set_slot(0, INST_CAT_LD, c, 14, STATUS_HIT, 32'h0bad_cafe);
  set_snoop(SNOOP_READ, c, STATUS_L1D_CONFLICT, '0);
  push_step();
  for (int n = 0; n < FILLER_NUM; n++) begin
    add_filler(n);
  end
endtask

// ------------------------------
// Step execution
// ------------------------------
task automatic run_step(input step_t s);
  int errs_before;
  int disp_cycle;
  int n;
  errs_before = err_cnt;
  @(posedge i_clk);
  i_disp_valid <= s.disp_valid;
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    i_disp_cat[p]     <= s.cat[p];
    i_disp_paddr[p]   <= s.paddr[p];
    i_disp_payload[p] <= s.payload[p];
  end
  i_fill_valid <= s.fill_valid;
  i_fill_paddr <= s.fill_paddr;
  i_fill_data  <= s.fill_data;
  @(negedge i_clk);
  disp_cycle = cycle_cnt;
  @(posedge i_clk);
  i_disp_valid  <= '0;
  i_fill_valid  <= 1'b0;
  i_snoop_valid <= s.snoop_valid;
  i_snoop_cmd   <= s.snoop_cmd;
  i_snoop_paddr <= s.snoop_paddr;
  @(posedge i_clk);
  i_snoop_valid <= 1'b0;

  if (s.snoop_valid) begin
    n = 0;
    @(negedge i_clk);
    while (!o_snoop_resp_valid && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_snoop_resp_valid) begin
      report_failure($sformatf("%s: no snoop response arrived", s.name));
    end else begin
      if (cycle_cnt - (disp_cycle + 1) != 1) begin
        report_failure($sformatf("%s: snoop response came late", s.name));
      end
      check_status({s.name, ".snoop status"}, s.exp_snoop_status, o_snoop_resp_status);
      check_data({s.name, ".snoop data"}, s.exp_snoop_data, o_snoop_resp_data);
    end
  end

  if (s.disp_valid != '0) begin
    n = 0;
    @(negedge i_clk);
    while (o_done_valid == '0 && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (o_done_valid == '0) begin
      report_failure($sformatf("%s: no done report arrived", s.name));
    end else begin
      if (cycle_cnt - disp_cycle != 3) begin
        report_failure($sformatf("%s: done report not 3 cycles after dispatch", s.name));
      end
      for (int p = 0; p < LSU_INST_NUM; p++) begin
        if (o_done_valid[p] !== s.disp_valid[p]) begin
          report_failure($sformatf("%s: pipe %0d done valid does not follow its slot",
                                   s.name, p));
        end
        check_status($sformatf("%s.p%0d status", s.name, p), s.exp_status[p],
                     o_done_status[p]);
        if (s.disp_valid[p]) begin
          check_data($sformatf("%s.p%0d data", s.name, p), s.exp_data[p], o_done_data[p]);
          check_rd_tag($sformatf("%s.p%0d rd_tag", s.name, p), s.exp_rd_tag[p],
                       o_done_rd_tag[p]);
        end
      end
    end
  end
  test_cnt++;
  $display("%-24s %s", s.name, (err_cnt == errs_before) ? "passed" : "FAILED");
endtask

initial begin
  i_clk         = 1'b0;
  i_reset_n     = 1'b0;
  i_disp_valid  = '0;
  i_fill_valid  = 1'b0;
  i_fill_paddr  = '0;
  i_fill_data   = '0;
  i_snoop_valid = 1'b0;
  i_snoop_cmd   = SNOOP_READ;
  i_snoop_paddr = '0;
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    i_disp_cat[p]     = INST_CAT_LD;
    i_disp_paddr[p]   = '0;
    i_disp_payload[p] = '0;
  end
  for (int l = 0; l < DCACHE_LINES; l++) begin
    m_valid[l] = 1'b0;
    m_tag[l]   = '0;
    m_data[l]  = '0;
  end
  seed = 32'hac44864c;
  build_table();

  repeat (16) @(posedge i_clk);
  i_reset_n <= 1'b1;

  // Nothing may be reported straight out of reset
  @(negedge i_clk);
  if (o_done_valid !== '0 || o_snoop_resp_valid !== 1'b0) begin
    report_failure("A valid output is high after reset");
  end
  for (int p = 0; p < LSU_INST_NUM; p++) begin
    check_status($sformatf("reset_idle.p%0d status", p), STATUS_NONE, o_done_status[p]);
  end
  test_cnt++;
  $display("%-24s %s", "reset_idle", (err_cnt == 0) ? "passed" : "FAILED");

  foreach (steps[i]) begin
    run_step(steps[i]);
  end

  err_cnt += dut.u_lsu_top_sva.fail_cnt;
  $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
  if (err_cnt == 0) begin
    $display("Everything OK");
  end else begin
    $display("Something failed");
  end
  $finish;
end

endmodule

// ==== vlog.f ====
hdl/lsu_conf_pkg.sv
hdl/lsu_types_pkg.sv
hdl/lsu_dispatch.sv
hdl/lsu_pipe.sv
hdl/lsu_dcache.sv
hdl/lsu_top.sv
verif/tb_lsu_top_sva.sv
verif/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_dcache_front

sources:
  # Packages first, then the design from the leaves up
  - files:
      - hdl/lsu_conf_pkg.sv
      - hdl/lsu_types_pkg.sv
      - hdl/lsu_dispatch.sv
      - hdl/lsu_pipe.sv
      - hdl/lsu_dcache.sv
      - hdl/lsu_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/tb_lsu_top_sva.sv
      - verif/tb_lsu_top.sv
